// File: logic/apu_pkg.sv
`default_nettype none

package apu_pkg;

  // register offsets within the 0x4000 page
  localparam logic [4:0] reg_pulse0_ctl = 5'h00;
  localparam logic [4:0] reg_pulse0_lo = 5'h02;
  localparam logic [4:0] reg_pulse0_hi = 5'h03;
  localparam logic [4:0] reg_pulse1_ctl = 5'h04;
  localparam logic [4:0] reg_pulse1_lo = 5'h06;
  localparam logic [4:0] reg_pulse1_hi = 5'h07;
  localparam logic [4:0] reg_noise_ctl = 5'h0C;
  localparam logic [4:0] reg_noise_period = 5'h0E;
  localparam logic [4:0] reg_noise_length = 5'h0F;
  localparam logic [4:0] reg_status = 5'h15;
  localparam logic [4:0] reg_frame = 5'h17;

  // linear mixer weights, full scale stays below 16 bits
  localparam logic [15:0] pulse_weight = 16'd752;
  localparam logic [15:0] noise_weight = 16'd494;

  localparam logic [7:0] length_lut [32] = '{
    8'd10, 8'd254, 8'd20, 8'd2, 8'd40, 8'd4, 8'd80, 8'd6,
    8'd160, 8'd8, 8'd60, 8'd10, 8'd14, 8'd12, 8'd26, 8'd14,
    8'd12, 8'd16, 8'd24, 8'd18, 8'd48, 8'd20, 8'd96, 8'd22,
    8'd192, 8'd24, 8'd72, 8'd26, 8'd16, 8'd28, 8'd32, 8'd30
  };

  localparam logic [11:0] noise_lut [16] = '{
    12'd4, 12'd8, 12'd16, 12'd32, 12'd64, 12'd96, 12'd128, 12'd160,
    12'd202, 12'd254, 12'd380, 12'd508, 12'd762, 12'd1016, 12'd2034, 12'd4068
  };

  function automatic logic [7:0] length_table(input logic [4:0] idx);
    return length_lut[idx];
  endfunction

  function automatic logic [11:0] noise_period(input logic [3:0] idx);
    return noise_lut[idx];
  endfunction

  // step 0 is the leftmost bit of each pattern
  function automatic logic duty_pattern(input logic [1:0] duty, input logic [2:0] step);
    logic [7:0] pattern;
    case (duty)
      2'd0: pattern = 8'b0100_0000;
      2'd1: pattern = 8'b0110_0000;
      2'd2: pattern = 8'b0111_1000;
      default: pattern = 8'b1001_1111;
    endcase
    return pattern[3'd7 - step];
  endfunction

endpackage

`default_nettype wire

// File: logic/apu_regs.sv
`timescale 1ns/1ps
`default_nettype none

module apu_regs
  import apu_pkg::*;
(
  input logic clk,
  input logic rst_l,
  input logic cpu_clk_en,
  input logic [4:0] addr,
  input logic [7:0] data_in,
  input logic we,
  input logic re,
  input logic [3:0] length_non_zero,
  input logic frame_irq,
  output logic [7:0] reg_data_out,
  output logic status_read,
  output logic [3:0] enable,
  output logic frame_write,
  output logic frame_mode,
  output logic irq_inhibit,
  output logic [1:0] pulse0_duty,
  output logic pulse0_halt,
  output logic pulse0_const_vol,
  output logic [3:0] pulse0_vol,
  output logic [10:0] pulse0_period,
  output logic [4:0] pulse0_length_idx,
  output logic pulse0_length_load,
  output logic pulse0_env_load,
  output logic [1:0] pulse1_duty,
  output logic pulse1_halt,
  output logic pulse1_const_vol,
  output logic [3:0] pulse1_vol,
  output logic [10:0] pulse1_period,
  output logic [4:0] pulse1_length_idx,
  output logic pulse1_length_load,
  output logic pulse1_env_load,
  output logic noise_halt,
  output logic noise_const_vol,
  output logic [3:0] noise_vol,
  output logic noise_mode,
  output logic [3:0] noise_period_idx,
  output logic [4:0] noise_length_idx,
  output logic noise_length_load,
  output logic noise_env_load
);

  logic [7:0] reg_file [24];

  always_ff @(posedge clk, negedge rst_l) begin
    if (!rst_l) begin
      for (int i = 0; i < 24; i++) begin
        reg_file[i] <= 8'h00;
      end
    end else if (cpu_clk_en && we && (addr <= reg_frame)) begin
      reg_file[addr] <= data_in;
    end
  end

  // strobes are held for one cpu cycle, so the fields are already updated
  always_ff @(posedge clk, negedge rst_l) begin
    if (!rst_l) begin
      pulse0_length_load <= 1'b0;
      pulse0_env_load <= 1'b0;
      pulse1_length_load <= 1'b0;
      pulse1_env_load <= 1'b0;
      noise_length_load <= 1'b0;
      noise_env_load <= 1'b0;
      frame_write <= 1'b0;
      enable <= 4'h0;
      reg_data_out <= 8'h00;
    end else if (cpu_clk_en) begin
      pulse0_length_load <= we && (addr == reg_pulse0_hi);
      pulse0_env_load <= we && (addr == reg_pulse0_ctl);
      pulse1_length_load <= we && (addr == reg_pulse1_hi);
      pulse1_env_load <= we && (addr == reg_pulse1_ctl);
      noise_length_load <= we && (addr == reg_noise_length);
      noise_env_load <= we && (addr == reg_noise_ctl);
      frame_write <= we && (addr == reg_frame);
      if (we && (addr == reg_status)) begin
        enable <= data_in[3:0];
      end
      if (re) begin
        reg_data_out <= (addr == reg_status) ? {1'b0, frame_irq, 2'b00, length_non_zero} :
                                               8'h00;
      end
    end
  end

  // frame counter qualifies this with cpu_clk_en
  assign status_read = re && (addr == reg_status);

  assign frame_mode = reg_file[reg_frame][7];
  assign irq_inhibit = reg_file[reg_frame][6];

  assign pulse0_duty = reg_file[reg_pulse0_ctl][7:6];
  assign pulse0_halt = reg_file[reg_pulse0_ctl][5];
  assign pulse0_const_vol = reg_file[reg_pulse0_ctl][4];
  assign pulse0_vol = reg_file[reg_pulse0_ctl][3:0];
  assign pulse0_period = {reg_file[reg_pulse0_hi][2:0], reg_file[reg_pulse0_lo]};
  assign pulse0_length_idx = reg_file[reg_pulse0_hi][7:3];

  assign pulse1_duty = reg_file[reg_pulse1_ctl][7:6];
  assign pulse1_halt = reg_file[reg_pulse1_ctl][5];
  assign pulse1_const_vol = reg_file[reg_pulse1_ctl][4];
  assign pulse1_vol = reg_file[reg_pulse1_ctl][3:0];
  assign pulse1_period = {reg_file[reg_pulse1_hi][2:0], reg_file[reg_pulse1_lo]};
  assign pulse1_length_idx = reg_file[reg_pulse1_hi][7:3];

  assign noise_halt = reg_file[reg_noise_ctl][5];
  assign noise_const_vol = reg_file[reg_noise_ctl][4];
  assign noise_vol = reg_file[reg_noise_ctl][3:0];
  assign noise_mode = reg_file[reg_noise_period][7];
  assign noise_period_idx = reg_file[reg_noise_period][3:0];
  assign noise_length_idx = reg_file[reg_noise_length][7:3];

endmodule

`default_nettype wire

// File: logic/frame_counter.sv
`timescale 1ns/1ps
`default_nettype none

module frame_counter (
  input logic clk,
  input logic rst_l,
  input logic apu_clk_en,
  input logic cpu_clk_en,
  input logic frame_write,
  input logic frame_mode,
  input logic irq_inhibit,
  input logic status_read,
  output logic quarter_tick,
  output logic half_tick,
  output logic frame_irq
);

  // step points in apu cycles after the frame write
  localparam logic [14:0] step1 = 15'd3729;
  localparam logic [14:0] step2 = 15'd7457;
  localparam logic [14:0] step3 = 15'd11186;
  localparam logic [14:0] step4 = 15'd14915;
  localparam logic [14:0] step5 = 15'd18641;

  logic [14:0] count;
  logic [14:0] count_next;
  logic last_step;
  logic half_hit;
  logic quarter_hit;
  logic irq_hit;

  assign count_next = count + 15'd1;

  // frame_mode high selects the 5-step sequence
  always_comb begin
    last_step = frame_mode ? (count_next == step5) : (count_next == step4);
    half_hit = (count_next == step2) || last_step;
    quarter_hit = (count_next == step1) || (count_next == step3) || half_hit;
    irq_hit = !frame_mode && !irq_inhibit && (count_next == step4);
  end

  always_ff @(posedge clk, negedge rst_l) begin
    if (!rst_l) begin
      count <= 15'd0;
      quarter_tick <= 1'b0;
      half_tick <= 1'b0;
    end else begin
      quarter_tick <= apu_clk_en && quarter_hit;
      half_tick <= apu_clk_en && half_hit;
      if (cpu_clk_en && frame_write) begin
        count <= 15'd0;
      end else if (apu_clk_en) begin
        count <= last_step ? 15'd0 : count_next;
      end
    end
  end

  // setting wins over a clear on the same edge
  always_ff @(posedge clk, negedge rst_l) begin
    if (!rst_l) begin
      frame_irq <= 1'b0;
    end else if (apu_clk_en && irq_hit) begin
      frame_irq <= 1'b1;
    end else if (cpu_clk_en && (status_read || (frame_write && irq_inhibit))) begin
      frame_irq <= 1'b0;
    end
  end

endmodule

`default_nettype wire

// File: logic/pulse_channel.sv
`timescale 1ns/1ps
`default_nettype none

module pulse_channel
  import apu_pkg::*;
(
  input logic clk,
  input logic rst_l,
  input logic apu_clk_en,
  input logic cpu_clk_en,
  input logic quarter_tick,
  input logic half_tick,
  input logic enable,
  input logic [1:0] duty,
  input logic halt,
  input logic const_vol,
  input logic [3:0] vol,
  input logic [10:0] period,
  input logic [4:0] length_idx,
  input logic length_load,
  input logic env_load,
  output logic length_non_zero,
  output logic [3:0] level
);

  logic [10:0] timer;
  logic [2:0] seq_step;
  logic env_start;
  logic [3:0] env_div;
  logic [3:0] env_decay;
  logic [7:0] length;
  logic load_now;
  logic env_now;

  // strobes last a whole cpu cycle, act on them once
  assign load_now = cpu_clk_en && length_load;
  assign env_now = cpu_clk_en && env_load;

  // a length write also restarts the duty sequence
  always_ff @(posedge clk, negedge rst_l) begin
    if (!rst_l) begin
      timer <= 11'd0;
      seq_step <= 3'd0;
    end else if (load_now) begin
      seq_step <= 3'd0;
    end else if (apu_clk_en) begin
      if (timer == 11'd0) begin
        timer <= period;
        seq_step <= seq_step + 3'd1;
      end else begin
        timer <= timer - 11'd1;
      end
    end
  end

  always_ff @(posedge clk, negedge rst_l) begin
    if (!rst_l) begin
      env_start <= 1'b0;
      env_div <= 4'd0;
      env_decay <= 4'd0;
    end else if (env_now) begin
      env_start <= 1'b1;
    end else if (quarter_tick) begin
      if (env_start) begin
        env_start <= 1'b0;
        env_decay <= 4'd15;
        env_div <= vol;
      end else if (env_div == 4'd0) begin
        env_div <= vol;
        // halt doubles as the envelope loop flag
        if (env_decay != 4'd0) begin
          env_decay <= env_decay - 4'd1;
        end else if (halt) begin
          env_decay <= 4'd15;
        end
      end else begin
        env_div <= env_div - 4'd1;
      end
    end
  end

  always_ff @(posedge clk, negedge rst_l) begin
    if (!rst_l) begin
      length <= 8'd0;
    end else if (!enable) begin
      length <= 8'd0;
    end else if (load_now) begin
      length <= length_table(length_idx);
    end else if (half_tick && !halt && (length != 8'd0)) begin
      length <= length - 8'd1;
    end
  end

  assign length_non_zero = (length != 8'd0);

  // periods below 8 would alias above audible range, mute them
  always_ff @(posedge clk, negedge rst_l) begin
    if (!rst_l) begin
      level <= 4'd0;
    end else if ((length == 8'd0) || (period < 11'd8) || !duty_pattern(duty, seq_step)) begin
      level <= 4'd0;
    end else begin
      level <= const_vol ? vol : env_decay;
    end
  end

endmodule

`default_nettype wire

// File: logic/noise_channel.sv
`timescale 1ns/1ps
`default_nettype none

module noise_channel
  import apu_pkg::*;
(
  input logic clk,
  input logic rst_l,
  input logic apu_clk_en,
  input logic quarter_tick,
  input logic half_tick,
  input logic enable,
  input logic halt,
  input logic const_vol,
  input logic [3:0] vol,
  input logic mode,
  input logic [3:0] period_idx,
  input logic [4:0] length_idx,
  input logic length_load,
  input logic env_load,
  output logic length_non_zero,
  output logic [3:0] level
);

  logic [11:0] timer;
  logic [14:0] lfsr;
  logic feedback;
  logic env_start;
  logic [3:0] env_div;
  logic [3:0] env_decay;
  logic [7:0] length;

  // short mode taps bit 6 for the metallic 93-step sequence
  assign feedback = lfsr[0] ^ (mode ? lfsr[6] : lfsr[1]);

  always_ff @(posedge clk, negedge rst_l) begin
    if (!rst_l) begin
      timer <= 12'd0;
      lfsr <= 15'd1;
    end else if (apu_clk_en) begin
      if (timer == 12'd0) begin
        timer <= noise_period(period_idx);
        lfsr <= {feedback, lfsr[14:1]};
      end else begin
        timer <= timer - 12'd1;
      end
    end
  end

  always_ff @(posedge clk, negedge rst_l) begin
    if (!rst_l) begin
      env_start <= 1'b0;
      env_div <= 4'd0;
      env_decay <= 4'd0;
    end else if (env_load) begin
      env_start <= 1'b1;
    end else if (quarter_tick) begin
      if (env_start) begin
        env_start <= 1'b0;
        env_decay <= 4'd15;
        env_div <= vol;
      end else if (env_div == 4'd0) begin
        env_div <= vol;
        if (env_decay != 4'd0) begin
          env_decay <= env_decay - 4'd1;
        end else if (halt) begin
          env_decay <= 4'd15;
        end
      end else begin
        env_div <= env_div - 4'd1;
      end
    end
  end

  always_ff @(posedge clk, negedge rst_l) begin
    if (!rst_l) begin
      length <= 8'd0;
    end else if (!enable) begin
      length <= 8'd0;
    end else if (length_load) begin
      length <= length_table(length_idx);
    end else if (half_tick && !halt && (length != 8'd0)) begin
      length <= length - 8'd1;
    end
  end

  assign length_non_zero = (length != 8'd0);

  always_ff @(posedge clk, negedge rst_l) begin
    if (!rst_l) begin
      level <= 4'd0;
    end else if ((length == 8'd0) || lfsr[0]) begin
      level <= 4'd0;
    end else begin
      level <= const_vol ? vol : env_decay;
    end
  end

endmodule

`default_nettype wire

// File: logic/apu_mixer.sv
`timescale 1ns/1ps
`default_nettype none

module apu_mixer
  import apu_pkg::*;
(
  input logic clk,
  input logic rst_l,
  input logic [3:0] pulse0,
  input logic [3:0] pulse1,
  input logic [3:0] noise,
  output logic [15:0] audio_out
);

  logic [15:0] pulse_sum;
  logic [15:0] noise_ext;
  logic [15:0] mix;

  assign pulse_sum = {12'd0, pulse0} + {12'd0, pulse1};
  assign noise_ext = {12'd0, noise};

  // largest sum is 30 * 752 + 15 * 494, no overflow
  assign mix = pulse_sum * pulse_weight + noise_ext * noise_weight;

  always_ff @(posedge clk, negedge rst_l) begin
    if (!rst_l) begin
      audio_out <= 16'd0;
    end else begin
      audio_out <= mix;
    end
  end

endmodule

`default_nettype wire

// File: logic/apu.sv
`timescale 1ns/1ps
`default_nettype none

module apu (
  input logic clk,
  input logic rst_l,
  input logic cpu_clk_en,
  input logic apu_clk_en,
  input logic [4:0] addr,
  input logic [7:0] data_in,
  input logic we,
  input logic re,
  output logic [7:0] reg_data_out,
  output logic irq_l,
  output logic [15:0] audio_out
);

  logic [3:0] enable;
  logic [3:0] length_non_zero;
  logic status_read;
  logic frame_write;
  logic frame_mode;
  logic irq_inhibit;
  logic quarter_tick;
  logic half_tick;
  logic frame_irq;

  logic [1:0] pulse0_duty;
  logic pulse0_halt;
  logic pulse0_const_vol;
  logic [3:0] pulse0_vol;
  logic [10:0] pulse0_period;
  logic [4:0] pulse0_length_idx;
  logic pulse0_length_load;
  logic pulse0_env_load;
  logic [3:0] pulse0_level;

  logic [1:0] pulse1_duty;
  logic pulse1_halt;
  logic pulse1_const_vol;
  logic [3:0] pulse1_vol;
  logic [10:0] pulse1_period;
  logic [4:0] pulse1_length_idx;
  logic pulse1_length_load;
  logic pulse1_env_load;
  logic [3:0] pulse1_level;

  logic noise_halt;
  logic noise_const_vol;
  logic [3:0] noise_vol;
  logic noise_mode;
  logic [3:0] noise_period_idx;
  logic [4:0] noise_length_idx;
  logic noise_length_load;
  logic noise_env_load;
  logic [3:0] noise_level;

  // bit 2 is the triangle slot, not built here
  assign length_non_zero[2] = 1'b0;
  assign irq_l = ~frame_irq;

  apu_regs regs_inst (
    .clk(clk), .rst_l(rst_l), .cpu_clk_en(cpu_clk_en),
    .addr(addr), .data_in(data_in), .we(we), .re(re),
    .length_non_zero(length_non_zero), .frame_irq(frame_irq),
    .reg_data_out(reg_data_out), .status_read(status_read), .enable(enable),
    .frame_write(frame_write), .frame_mode(frame_mode), .irq_inhibit(irq_inhibit),
    .pulse0_duty(pulse0_duty), .pulse0_halt(pulse0_halt),
    .pulse0_const_vol(pulse0_const_vol), .pulse0_vol(pulse0_vol),
    .pulse0_period(pulse0_period), .pulse0_length_idx(pulse0_length_idx),
    .pulse0_length_load(pulse0_length_load), .pulse0_env_load(pulse0_env_load),
    .pulse1_duty(pulse1_duty), .pulse1_halt(pulse1_halt),
    .pulse1_const_vol(pulse1_const_vol), .pulse1_vol(pulse1_vol),
    .pulse1_period(pulse1_period), .pulse1_length_idx(pulse1_length_idx),
    .pulse1_length_load(pulse1_length_load), .pulse1_env_load(pulse1_env_load),
    .noise_halt(noise_halt), .noise_const_vol(noise_const_vol), .noise_vol(noise_vol),
    .noise_mode(noise_mode), .noise_period_idx(noise_period_idx),
    .noise_length_idx(noise_length_idx), .noise_length_load(noise_length_load),
    .noise_env_load(noise_env_load)
  );

  frame_counter frame_inst (
    .clk(clk), .rst_l(rst_l), .apu_clk_en(apu_clk_en), .cpu_clk_en(cpu_clk_en),
    .frame_write(frame_write), .frame_mode(frame_mode), .irq_inhibit(irq_inhibit),
    .status_read(status_read), .quarter_tick(quarter_tick), .half_tick(half_tick),
    .frame_irq(frame_irq)
  );

  pulse_channel pulse0_inst (
    .clk(clk), .rst_l(rst_l), .apu_clk_en(apu_clk_en), .cpu_clk_en(cpu_clk_en),
    .quarter_tick(quarter_tick), .half_tick(half_tick), .enable(enable[0]),
    .duty(pulse0_duty), .halt(pulse0_halt), .const_vol(pulse0_const_vol),
    .vol(pulse0_vol), .period(pulse0_period), .length_idx(pulse0_length_idx),
    .length_load(pulse0_length_load), .env_load(pulse0_env_load),
    .length_non_zero(length_non_zero[0]), .level(pulse0_level)
  );

  pulse_channel pulse1_inst (
    .clk(clk), .rst_l(rst_l), .apu_clk_en(apu_clk_en), .cpu_clk_en(cpu_clk_en),
    .quarter_tick(quarter_tick), .half_tick(half_tick), .enable(enable[1]),
    .duty(pulse1_duty), .halt(pulse1_halt), .const_vol(pulse1_const_vol),
    .vol(pulse1_vol), .period(pulse1_period), .length_idx(pulse1_length_idx),
    .length_load(pulse1_length_load), .env_load(pulse1_env_load),
    .length_non_zero(length_non_zero[1]), .level(pulse1_level)
  );

  noise_channel noise_inst (
    .clk(clk), .rst_l(rst_l), .apu_clk_en(apu_clk_en),
    .quarter_tick(quarter_tick), .half_tick(half_tick), .enable(enable[3]),
    .halt(noise_halt), .const_vol(noise_const_vol), .vol(noise_vol),
    .mode(noise_mode), .period_idx(noise_period_idx), .length_idx(noise_length_idx),
    .length_load(noise_length_load), .env_load(noise_env_load),
    .length_non_zero(length_non_zero[3]), .level(noise_level)
  );

  apu_mixer mixer_inst (
    .clk(clk), .rst_l(rst_l), .pulse0(pulse0_level), .pulse1(pulse1_level),
    .noise(noise_level), .audio_out(audio_out)
  );

endmodule

`default_nettype wire

// File: tests/apu_checker.sv
`timescale 1ns/1ps
`default_nettype none

module apu_checker (
  input logic clk,
  input logic rst_l,
  input logic irq_l,
  input logic quarter_tick,
  input logic half_tick,
  input logic [3:0] enable,
  input logic [15:0] audio_out
);

  irq_released_in_reset: assert property (@(posedge clk) !rst_l |-> irq_l)
    else $error("irq_l low while reset is held");

  quarter_tick_single: assert property (@(posedge clk) disable iff (!rst_l)
      quarter_tick |=> !quarter_tick)
    else $error("quarter_tick held for two cycles");

  half_tick_single: assert property (@(posedge clk) disable iff (!rst_l)
      half_tick |=> !half_tick)
    else $error("half_tick held for two cycles");

  // length, level and mixer registers sit between enable and audio_out
  silent_when_disabled: assert property (@(posedge clk) disable iff (!rst_l)
      ((enable == 4'h0) && ($past(enable, 1) == 4'h0) && ($past(enable, 2) == 4'h0) &&
       ($past(enable, 3) == 4'h0)) |-> (audio_out == 16'd0))
    else $error("audio_out not zero with every voice disabled");

endmodule

bind apu apu_checker checker_inst (
  .clk(clk),
  .rst_l(rst_l),
  .irq_l(irq_l),
  .quarter_tick(quarter_tick),
  .half_tick(half_tick),
  .enable(enable),
  .audio_out(audio_out)
);

`default_nettype wire

// File: tests/apu_tb.sv
`timescale 1ns/1ps
`default_nettype none

module apu_tb;

  // irq wait limit in apu cycles just above one 4-step frame
  localparam int irq_timeout = 15000;
  localparam int audio_samples = 64;
  // apu cycles between audio samples so the window spans a full pulse waveform
  localparam int sample_spacing = 16;
  localparam logic [4:0] status_addr = 5'h15;

  logic clk;
  logic rst_l;
  logic cpu_clk_en;
  logic apu_clk_en;
  logic [4:0] addr;
  logic [7:0] data_in;
  logic we;
  logic re;
  logic [7:0] reg_data_out;
  logic irq_l;
  logic [15:0] audio_out;

  apu apu_inst (
    .clk(clk),
    .rst_l(rst_l),
    .cpu_clk_en(cpu_clk_en),
    .apu_clk_en(apu_clk_en),
    .addr(addr),
    .data_in(data_in),
    .we(we),
    .re(re),
    .reg_data_out(reg_data_out),
    .irq_l(irq_l),
    .audio_out(audio_out)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #2 clk = ~clk;
    end
  end

  // apu strobe on every second cpu cycle
  initial begin
    apu_clk_en = 1'b0;
    forever begin
      @(posedge clk);
      #1;
      apu_clk_en = ~apu_clk_en;
    end
  end

  task automatic check_equal(input logic [31:0] actual, input logic [31:0] expected,
                             input string what);
    if (actual !== expected) begin
      $display("FAILED at %0t ns: %s: got 0x%0h, expected 0x%0h", $time, what, actual,
               expected);
      $display("Errors found");
      $fatal(1);
    end
  endtask

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("Errors found");
    $fatal(1);
  endtask

  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  // the load strobe is registered, give it one idle cycle to act
  task automatic write_reg(input logic [4:0] a, input logic [7:0] d);
    addr = a;
    data_in = d;
    we = 1'b1;
    next_cycle();
    we = 1'b0;
    next_cycle();
  endtask

  // read data is registered on the read edge
  task automatic read_check(input logic [4:0] a, input logic [7:0] expected);
    addr = a;
    re = 1'b1;
    next_cycle();
    re = 1'b0;
    check_equal({24'd0, reg_data_out}, {24'd0, expected},
                $sformatf("read of register 0x%0h", a));
  endtask

  task automatic wait_apu(input int n);
    int seen;
    int guard;
    seen = 0;
    guard = 0;
    while ((seen < n) && (guard < 2 * n + 4)) begin
      @(posedge clk);
      if (apu_clk_en) begin
        seen++;
      end
      guard++;
    end
    if (seen < n) begin
      abort_run($sformatf("apu strobe stopped while waiting for %0d apu cycles", n));
    end else begin
      #1;
    end
  endtask

  task automatic wait_irq(input logic value);
    int cycles;
    cycles = 0;
    while ((irq_l !== value) && (cycles < 2 * irq_timeout)) begin
      next_cycle();
      cycles++;
    end
    if (irq_l !== value) begin
      abort_run($sformatf("timeout waiting for irq_l to become %0d", value));
    end
  endtask

  // every sample is silence or the expected level and both must show up
  task automatic check_audio(input logic [15:0] level);
    bit seen_zero;
    bit seen_level;
    seen_zero = 1'b0;
    seen_level = 1'b0;
    for (int n = 0; n < audio_samples; n++) begin
      wait_apu(sample_spacing);
      if (audio_out == 16'd0) begin
        seen_zero = 1'b1;
      end else begin
        check_equal({16'd0, audio_out}, {16'd0, level}, "audio sample");
        seen_level = 1'b1;
      end
    end
    check_equal({31'd0, seen_zero}, 32'd1, "audio silent phase present");
    check_equal({31'd0, seen_level}, 32'd1, "audio active phase present");
  endtask

  task automatic run_command(input string line);
    string cmd;
    int fields;
    int arg_a;
    int arg_b;
    cmd = "";
    arg_a = 0;
    arg_b = 0;
    fields = $sscanf(line, "%s", cmd);
    if ((fields >= 1) && (cmd.substr(0, 0) != "#")) begin
      if ((cmd == "W") || (cmd == "R")) begin
        fields = $sscanf(line, "%s %h %h", cmd, arg_a, arg_b);
        if (fields != 3) begin
          abort_run($sformatf("malformed register line: %s", line));
        end else if (cmd == "W") begin
          write_reg(arg_a[4:0], arg_b[7:0]);
        end else begin
          read_check(arg_a[4:0], arg_b[7:0]);
        end
      end else begin
        fields = $sscanf(line, "%s %d", cmd, arg_a);
        if (fields != 2) begin
          abort_run($sformatf("malformed command line: %s", line));
        end else if (cmd == "WAIT") begin
          wait_apu(arg_a);
        end else if (cmd == "IRQ") begin
          wait_irq(arg_a[0]);
        end else if (cmd == "AUDIO") begin
          check_audio(arg_a[15:0]);
        end else begin
          abort_run($sformatf("unknown command in data file: %s", cmd));
        end
      end
    end
  endtask

  initial begin
    int fd;
    string line;
    rst_l = 1'b0;
    cpu_clk_en = 1'b1;
    addr = 5'd0;
    data_in = 8'd0;
    we = 1'b0;
    re = 1'b0;
    repeat (8) @(posedge clk);
    #1;
    rst_l = 1'b1;
    next_cycle();
    fd = $fopen("tests/apu_testdata.txt", "r");
    if (fd == 0) begin
      abort_run("could not open tests/apu_testdata.txt");
    end else begin
      while (!$feof(fd)) begin
        line = "";
        if ($fgets(line, fd) > 0) begin
          run_command(line);
        end
      end
      $fclose(fd);
      // disable every voice while noise still sounds so audio drops to zero
      write_reg(status_addr, 8'h00);
      repeat (4) next_cycle();
      check_equal({16'd0, audio_out}, 32'd0, "audio with every voice disabled");
      $display("No errors");
      $finish;
    end
  end

endmodule

`default_nettype wire

// File: tests/apu_testdata.txt
# W addr data, R addr expected (hex); WAIT apu_cycles, IRQ level, AUDIO sample (decimal)
# status: bit 6 frame irq, bits 3..0 length flags (bit 2 has no voice)
R 15 00
W 17 40
W 15 0F
W 03 08
W 07 08
W 0F 08
R 15 0B
W 15 00
R 15 00
# length countdown, pulse1 index 3 holds a count of 2
W 15 0F
W 00 10
W 04 10
W 0C 10
W 17 40
W 03 08
W 07 18
W 0F 08
WAIT 15000
R 15 09
WAIT 45000
R 15 09
# 4-step frame interrupt, cleared by status read and by an inhibit write
W 15 00
W 17 00
IRQ 0
R 15 40
IRQ 1
IRQ 0
W 17 40
IRQ 1
R 15 00
# 5-step mode
W 17 80
WAIT 20000
IRQ 1
R 15 00
# pulse0 alone, 50 percent duty, constant volume 9, period 100: 9 * 752
W 15 01
W 00 B9
W 02 64
W 03 08
WAIT 4
AUDIO 6768
# noise alone, constant volume 5: 5 * 494
W 15 08
W 0C 35
W 0E 00
W 0F 08
WAIT 4
AUDIO 2470

// File: sim.f
logic/apu_pkg.sv
logic/apu_regs.sv
logic/frame_counter.sv
logic/pulse_channel.sv
logic/noise_channel.sv
logic/apu_mixer.sv
logic/apu.sv
tests/apu_checker.sv
tests/apu_tb.sv

// File: Makefile
SRCS := $(shell cat sim.f)

.PHONY: run clean

run: obj_dir/Vapu_tb
	./obj_dir/Vapu_tb | tee sim.log
	grep -q "No errors" sim.log

obj_dir/Vapu_tb: sim.f $(SRCS)
	verilator --binary --timing --assert --top-module apu_tb -f sim.f -Mdir obj_dir -o Vapu_tb

clean:
	rm -rf obj_dir sim.log
